// ==== project.f ====
verilog/game_pkg.sv
verilog/display_pkg.sv
verilog/guess_capture.sv
verilog/pattern_lfsr.sv
verilog/game_fsm.sv
verilog/status_output.sv
verilog/memory_game_top.sv
test/game_chk.sv
test/game_monitor.sv
test/memory_game_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = memory_game_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== test/memory_game_tb.sv ====
`timescale 1ns/1ps

module memory_game_tb;

    localparam int SHOW_CYCLES = 16;
    localparam int BEEP_CYCLES = 6;
    localparam int SCAN_DIV    = 2;
    localparam int NUM_TESTS   = 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * (SHOW_CYCLES + 20);

    typedef enum logic [1:0] {ACT_RIGHT, ACT_WRONG, ACT_EARLY, ACT_DISARM} act_e;

    // round played in the test and lamps led[15:12] expected after it
    typedef struct packed
    {
        act_e       act;
        logic [1:0] round;
        logic [3:0] lamps;
    } entry_t;

    entry_t table_q [NUM_TESTS] = '{
        '{ACT_RIGHT,  2'd0, 4'b0100},
        '{ACT_WRONG,  2'd1, 4'b0100},
        '{ACT_RIGHT,  2'd1, 4'b1000},
        '{ACT_EARLY,  2'd2, 4'b1001},
        '{ACT_DISARM, 2'd2, 4'b0000},
        '{ACT_WRONG,  2'd0, 4'b0010},
        '{ACT_EARLY,  2'd0, 4'b0100},
        '{ACT_DISARM, 2'd1, 4'b0000}
    };

    logic        clk;
    logic        sw;
    logic        arm;
    logic        start;
    logic [6:0]  guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic        beep;
    logic [31:0] rand_state;
    int          cycles = 0;

    memory_game_top #(
        .SHOW_CYCLES (SHOW_CYCLES),
        .BEEP_CYCLES (BEEP_CYCLES),
        .SCAN_DIV    (SCAN_DIV)
    ) uut (
        .clk   (clk),
        .sw    (sw),
        .arm   (arm),
        .start (start),
        .guess (guess),
        .led   (led),
        .seg   (seg),
        .dig   (dig),
        .beep  (beep)
    );

    game_monitor #(
        .SCAN_DIV    (SCAN_DIV),
        .BEEP_CYCLES (BEEP_CYCLES)
    ) mon (
        .clk  (clk),
        .led  (led),
        .seg  (seg),
        .dig  (dig),
        .beep (beep)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    task automatic take_bits(input int n, output int value);
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            fb = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
            rand_state = {rand_state[30:0], fb};
            value = (value << 1) | int'(fb);
        end
    endtask

    task automatic wait_state(input game_pkg::game_state_e target);
        do
            @(negedge clk);
        while (uut.u_fsm.state != target);
    endtask

    task automatic press_start(input logic [6:0] value);
        guess = value;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        logic [6:0] pat;
        int         pick;
        int         width;
        act_e       prev;
        sw = 1'b1;
        arm = 1'b0;
        start = 1'b0;
        guess = '0;
        rand_state = 32'h74eb;
        prev = ACT_RIGHT;
        repeat (5) @(negedge clk);
        sw = 1'b0;
        @(negedge clk);
        mon.check_reset();
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            width = game_pkg::ROUND_WIDTH[table_q[t].round];
            mon.begin_test(t, table_q[t].act.name());
            if (table_q[t].act == ACT_DISARM)
            begin
                arm = 1'b0;
                repeat (2) @(negedge clk);
            end
            else
            begin
                arm = 1'b1;
                wait_state(game_pkg::SHOW);
                pat = led[6:0];
                mon.check_show(table_q[t].round, prev == ACT_WRONG);
                if (table_q[t].act == ACT_EARLY)
                    press_start(pat);
                wait_state(game_pkg::PLAY);
                if (table_q[t].act != ACT_EARLY)
                begin
                    mon.check_display(table_q[t].round, display_pkg::LET_P);
                    if (table_q[t].act == ACT_WRONG)
                    begin
                        take_bits(3, pick);
                        press_start(pat ^ (7'd1 << (pick % width)));
                    end
                    else
                        press_start(pat);
                end
                wait_state(game_pkg::JUDGE);
                @(negedge clk);
                if (table_q[t].act == ACT_WRONG)
                    mon.check_beep();
            end
            mon.end_test(table_q[t].lamps);
            if (table_q[t].lamps[0])
                mon.check_display(2'd2, display_pkg::LET_G);
            prev = table_q[t].act;
        end
        mon.report();
        if (mon.errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== test/game_monitor.sv ====
`timescale 1ns/1ps

module game_monitor #(
    parameter int SCAN_DIV    = 2,
    parameter int BEEP_CYCLES = 6
) (
    input logic        clk,
    input logic [15:0] led,
    input logic [7:0]  seg,
    input logic [7:0]  dig,
    input logic        beep
);

    int          errors = 0;
    int          tests = 0;
    int          test_errors = 0;
    int          test_idx = 0;
    string       test_name;
    logic [6:0]  last_pattern = '0;

    task automatic expect_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("error at %0t ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic check_reset();
        expect_val("led", 16'h0000, led);
        expect_val("beep", 16'(1'b0), 16'(beep));
        expect_val("dig", 16'h00FF, 16'(dig));
    endtask

    task automatic begin_test(input int idx, input string name);
        test_idx = idx;
        test_name = name;
        test_errors = 0;
    endtask

    // the pattern sits in the low bits, masked to the round width
    task automatic check_show(input logic [1:0] round, input logic same);
        logic [6:0] mask;
        logic [2:0] lamps;
        mask = 7'((8'd1 << game_pkg::ROUND_WIDTH[round]) - 8'd1);
        lamps = {round == 2'd2, round == 2'd1, round == 2'd0};
        expect_val("led[15:13]", 16'(lamps), 16'(led[15:13]));
        expect_val("led[12:7]", 16'h0000, 16'(led[12:7]));
        expect_val("led[6:0] above width", 16'h0000, 16'(led[6:0] & ~mask));
        if (same)
            expect_val("replayed pattern", 16'(last_pattern), 16'(led[6:0]));
        last_pattern = led[6:0];
    endtask

    task automatic check_beep();
        int   toggles;
        logic prev;
        toggles = 0;
        prev = beep;
        repeat (BEEP_CYCLES + 4)
        begin
            @(negedge clk);
            if (beep != prev)
                toggles++;
            prev = beep;
        end
        if (toggles < BEEP_CYCLES)
            complain($sformatf("buzzer toggled only %0d times after a wrong guess", toggles));
    endtask

    task automatic wait_digit(input logic [7:0] sel, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < 2 * SCAN_DIV + 2 && !seen; i++)
        begin
            if (dig == sel)
                seen = 1'b1;
            else
                @(negedge clk);
        end
    endtask

    task automatic check_display(input logic [1:0] round, input int letter);
        logic seen;
        wait_digit(8'hFE, seen);
        if (!seen)
            complain("round digit was never selected");
        else
            expect_val("seg digit", 16'(display_pkg::SEG_DIGIT[round + 1]), 16'(seg));
        wait_digit(8'hFD, seen);
        if (!seen)
            complain("status letter digit was never selected");
        else
            expect_val("seg letter", 16'(display_pkg::SEG_LETTER[letter]), 16'(seg));
    endtask

    task automatic end_test(input logic [3:0] lamps);
        expect_val("led[15:12]", 16'(lamps), 16'(led[15:12]));
        if (lamps == 4'b0000)
            expect_val("led", 16'h0000, led);
        tests++;
        if (test_errors == 0)
            $display("test %0d %s passed", test_idx, test_name);
        else
            $display("test %0d %s failed with %0d errors", test_idx, test_name, test_errors);
    endtask

    task automatic report();
        $display("tests run %0d, errors %0d", tests, errors);
    endtask

endmodule

// ==== test/game_chk.sv ====
`timescale 1ns/1ps

module game_chk (
    input logic                              clk,
    input logic                              sw,
    input game_pkg::game_state_e             state,
    input logic                              draw,
    input logic [15:0]                       led,
    input logic                              guess_valid,
    input logic                              guess_ready,
    input logic [game_pkg::PATTERN_BITS-1:0] guess_value
);

    // a waiting guess stays raised and unchanged
    hold_guess: assert property (@(posedge clk) disable iff (sw)
        guess_valid && !guess_ready |=> guess_valid && $stable(guess_value))
        else $error("guess dropped or changed while waiting");

    judge_once: assert property (@(posedge clk) disable iff (sw)
        state == game_pkg::JUDGE |=> state != game_pkg::JUDGE)
        else $error("JUDGE lasted more than one cycle");

    // outside IDLE exactly one round lamp is lit
    round_lamps: assert property (@(posedge clk) disable iff (sw)
        state != game_pkg::IDLE |-> $onehot(led[15:13]))
        else $error("round lamps not one-hot outside IDLE");

    single_draw: assert property (@(posedge clk) disable iff (sw)
        draw |=> !draw)
        else $error("draw high two cycles in a row");

endmodule

bind game_fsm game_chk chk (
    .clk         (clk),
    .sw          (sw),
    .state       (state),
    .draw        (draw),
    .led         (led),
    .guess_valid (guess_valid),
    .guess_ready (guess_ready),
    .guess_value (guess_value)
);

// ==== verilog/memory_game_top.sv ====
`timescale 1ns/1ps

module memory_game_top #(
    parameter int SHOW_CYCLES = 150_000_000,
    parameter int BEEP_CYCLES = 25_000_000,
    parameter int SCAN_DIV    = 50_000
) (
    input  logic                              clk,
    input  logic                              sw,
    input  logic                              arm,
    input  logic                              start,
    input  logic [game_pkg::PATTERN_BITS-1:0] guess,
    output logic [15:0]                       led,
    output logic [7:0]                        seg,
    output logic [7:0]                        dig,
    output logic                              beep
);

    logic                              guess_valid;
    logic                              guess_ready;
    logic [game_pkg::PATTERN_BITS-1:0] guess_value;
    logic                              draw;
    logic [game_pkg::PATTERN_BITS-1:0] pattern;
    game_pkg::game_state_e             state;
    logic [1:0]                        round;
    logic                              tone_req;
    display_pkg::tone_e                tone_kind;

    guess_capture u_capture (
        .clk         (clk),
        .sw          (sw),
        .start       (start),
        .guess       (guess),
        .guess_valid (guess_valid),
        .guess_value (guess_value),
        .guess_ready (guess_ready)
    );

    pattern_lfsr u_lfsr (
        .clk     (clk),
        .sw      (sw),
        .draw    (draw),
        .pattern (pattern)
    );

    game_fsm #(
        .SHOW_CYCLES (SHOW_CYCLES)
    ) u_fsm (
        .clk         (clk),
        .sw          (sw),
        .arm         (arm),
        .guess_valid (guess_valid),
        .guess_value (guess_value),
        .guess_ready (guess_ready),
        .pattern     (pattern),
        .draw        (draw),
        .led         (led),
        .state       (state),
        .round       (round),
        .tone_req    (tone_req),
        .tone_kind   (tone_kind)
    );

    status_output #(
        .SCAN_DIV    (SCAN_DIV),
        .BEEP_CYCLES (BEEP_CYCLES)
    ) u_status (
        .clk       (clk),
        .sw        (sw),
        .state     (state),
        .round     (round),
        .tone_req  (tone_req),
        .tone_kind (tone_kind),
        .seg       (seg),
        .dig       (dig),
        .beep      (beep)
    );

endmodule

// ==== verilog/status_output.sv ====
`timescale 1ns/1ps

module status_output #(
    parameter int SCAN_DIV    = 50000,
    parameter int BEEP_CYCLES = 1000
) (
    input  logic                  clk,
    input  logic                  sw,
    input  game_pkg::game_state_e state,
    input  logic [1:0]            round,
    input  logic                  tone_req,
    input  display_pkg::tone_e    tone_kind,
    output logic [7:0]            seg,
    output logic [7:0]            dig,
    output logic                  beep
);

    localparam int SCAN_W = $clog2(SCAN_DIV + 1);
    localparam int BEEP_W = $clog2(BEEP_CYCLES + 1);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);
    localparam logic [BEEP_W-1:0] BEEP_LEN  = BEEP_W'(BEEP_CYCLES);

    logic [SCAN_W-1:0]  scan_cnt;
    logic               sel;
    logic [BEEP_W-1:0]  beep_cnt;
    logic               phase;
    logic               err_tone;
    logic [7:0]         letter;
    display_pkg::tone_e kind_q;

    // digit select flips every SCAN_DIV cycles
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt <= '0;
            sel      <= 1'b0;
        end
        else if (scan_cnt == SCAN_LAST)
        begin
            scan_cnt <= '0;
            sel      <= !sel;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // win tone toggles at half the rate
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            beep_cnt <= '0;
            phase    <= 1'b0;
            beep     <= 1'b0;
            kind_q   <= display_pkg::TONE_OFF;
        end
        else if (tone_req && tone_kind != display_pkg::TONE_OFF)
        begin
            beep_cnt <= BEEP_LEN;
            phase    <= 1'b0;
            kind_q   <= tone_kind;
        end
        else if (beep_cnt != '0)
        begin
            beep_cnt <= beep_cnt - 1'b1;
            phase    <= !phase;
            if (kind_q == display_pkg::TONE_ERROR || phase)
                beep <= !beep;
        end
        else
            beep <= 1'b0;
    end

    assign err_tone = (beep_cnt != '0) && (kind_q == display_pkg::TONE_ERROR);

    always_comb
    begin
        if (err_tone)
            letter = display_pkg::SEG_LETTER[display_pkg::LET_E];
        else if (state == game_pkg::SHOW)
            letter = display_pkg::SEG_LETTER[display_pkg::LET_S];
        else if (state == game_pkg::WIN)
            letter = display_pkg::SEG_LETTER[display_pkg::LET_G];
        else
            letter = display_pkg::SEG_LETTER[display_pkg::LET_P];
    end

    // display dark while the game is not armed; dig is active low
    always_comb
    begin
        if (state == game_pkg::IDLE)
        begin
            seg = display_pkg::SEG_BLANK;
            dig = 8'hFF;
        end
        else if (sel)
        begin
            seg = letter;
            dig = 8'hFD;
        end
        else
        begin
            seg = display_pkg::SEG_DIGIT[round + 2'd1];
            dig = 8'hFE;
        end
    end

endmodule

// ==== verilog/game_fsm.sv ====
`timescale 1ns/1ps

module game_fsm #(
    parameter int SHOW_CYCLES = 1000
) (
    input  logic                              clk,
    input  logic                              sw,
    input  logic                              arm,
    input  logic                              guess_valid,
    input  logic [game_pkg::PATTERN_BITS-1:0] guess_value,
    output logic                              guess_ready,
    input  logic [game_pkg::PATTERN_BITS-1:0] pattern,
    output logic                              draw,
    output logic [15:0]                       led,
    output game_pkg::game_state_e             state,
    output logic [1:0]                        round,
    output logic                              tone_req,
    output display_pkg::tone_e                tone_kind
);

    localparam int TIMER_W = $clog2(SHOW_CYCLES + 1);
    localparam logic [TIMER_W-1:0] SHOW_LAST = TIMER_W'(SHOW_CYCLES - 1);

    logic                              arm_prev;
    logic                              arm_rise;
    logic                              take;
    logic                              match;
    logic [TIMER_W-1:0]                show_cnt;
    logic [game_pkg::PATTERN_BITS-1:0] guess_q;
    logic [game_pkg::PATTERN_BITS-1:0] round_mask;

    assign arm_rise    = arm && !arm_prev;
    assign guess_ready = (state == game_pkg::PLAY);
    assign take        = guess_valid && guess_ready;

    // only the low bits of the current round count
    always_comb
    begin
        round_mask = '0;
        for (int i = 0; i < game_pkg::PATTERN_BITS; i++)
            round_mask[i] = (i < game_pkg::ROUND_WIDTH[round]);
    end

    assign match = ((guess_q ^ pattern) & round_mask) == '0;

    // new pattern on arming and after a good guess below the last round
    assign draw = (state == game_pkg::IDLE && arm_rise)
               || (state == game_pkg::JUDGE && arm && match && round != 2'd2);

    always_ff @(posedge clk)
    begin
        if (take)
            guess_q <= guess_value;
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state     <= game_pkg::IDLE;
            round     <= 2'd0;
            show_cnt  <= '0;
            arm_prev  <= 1'b0;
            tone_req  <= 1'b0;
            tone_kind <= display_pkg::TONE_OFF;
        end
        else
        begin
            arm_prev <= arm;
            tone_req <= 1'b0;
            // timer runs only inside SHOW, so every entry starts at zero
            if (state == game_pkg::SHOW)
                show_cnt <= show_cnt + 1'b1;
            else
                show_cnt <= '0;
            if (!arm)
            begin
                state <= game_pkg::IDLE;
                round <= 2'd0;
            end
            else
            begin
                case (state)
                    game_pkg::IDLE:
                        if (arm_rise)
                            state <= game_pkg::SHOW;
                    game_pkg::SHOW:
                        if (show_cnt == SHOW_LAST)
                            state <= game_pkg::PLAY;
                    game_pkg::PLAY:
                        if (take)
                            state <= game_pkg::JUDGE;
                    game_pkg::JUDGE:
                    begin
                        if (!match)
                        begin
                            // replay the same round with the same pattern
                            state     <= game_pkg::SHOW;
                            tone_req  <= 1'b1;
                            tone_kind <= display_pkg::TONE_ERROR;
                        end
                        else if (round != 2'd2)
                        begin
                            round <= round + 2'd1;
                            state <= game_pkg::SHOW;
                        end
                        else
                        begin
                            state     <= game_pkg::WIN;
                            tone_req  <= 1'b1;
                            tone_kind <= display_pkg::TONE_WIN;
                        end
                    end
                    game_pkg::WIN:
                        state <= game_pkg::WIN;
                    default:
                        state <= game_pkg::IDLE;
                endcase
            end
        end
    end

    // pattern in SHOW, one-hot round on top, victory lamp in WIN
    always_comb
    begin
        led = '0;
        if (state == game_pkg::SHOW)
            led[game_pkg::PATTERN_BITS-1:0] = pattern & round_mask;
        if (state != game_pkg::IDLE)
            led[15:13] = 3'b001 << round;
        led[12] = (state == game_pkg::WIN);
    end

endmodule

// ==== verilog/pattern_lfsr.sv ====
`timescale 1ns/1ps

module pattern_lfsr (
    input  logic                              clk,
    input  logic                              sw,
    input  logic                              draw,
    output logic [game_pkg::PATTERN_BITS-1:0] pattern
);

    // taps of x^16 + x^14 + x^13 + x^11 + 1 for a right shift
    localparam logic [game_pkg::LFSR_BITS-1:0] TAPS = 'hB400;
    localparam logic [game_pkg::LFSR_BITS-1:0] SEED = 'hACE1;

    logic [game_pkg::LFSR_BITS-1:0] lfsr;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= SEED;
        else if (lfsr[0])
            lfsr <= (lfsr >> 1) ^ TAPS;
        else
            lfsr <= lfsr >> 1;
    end

    // held until the next draw
    always_ff @(posedge clk)
    begin
        if (draw)
            pattern <= lfsr[game_pkg::PATTERN_BITS-1:0];
    end

endmodule

// ==== verilog/guess_capture.sv ====
`timescale 1ns/1ps

module guess_capture (
    input  logic                              clk,
    input  logic                              sw,
    input  logic                              start,
    input  logic [game_pkg::PATTERN_BITS-1:0] guess,
    output logic                              guess_valid,
    output logic [game_pkg::PATTERN_BITS-1:0] guess_value,
    input  logic                              guess_ready
);

    logic start_sync;
    logic start_prev;
    logic start_rise;

    assign start_rise = start_sync && !start_prev;

    // sync the button, then look for the press edge
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            start_sync  <= 1'b0;
            start_prev  <= 1'b0;
            guess_valid <= 1'b0;
        end
        else
        begin
            start_sync <= start;
            start_prev <= start_sync;
            // a press while a guess is pending is dropped
            if (guess_valid && guess_ready)
                guess_valid <= 1'b0;
            else if (start_rise)
                guess_valid <= 1'b1;
        end
    end

    // switches are frozen when the request is raised
    always_ff @(posedge clk)
    begin
        if (!guess_valid && start_rise)
            guess_value <= guess;
    end

endmodule

// ==== verilog/display_pkg.sv ====
package display_pkg;

    // buzzer modes requested by the controller
    typedef enum logic [1:0]
    {
        TONE_OFF,
        TONE_ERROR,
        TONE_WIN
    } tone_e;

    // active low segment codes in bit order {dp, g, f, e, d, c, b, a}
    localparam logic [7:0] SEG_DIGIT [10] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
    };

    // letter table order is P, S, E, G
    localparam int LET_P = 0;
    localparam int LET_S = 1;
    localparam int LET_E = 2;
    localparam int LET_G = 3;
    localparam logic [7:0] SEG_LETTER [4] = '{8'h8C, 8'h92, 8'h86, 8'hC2};

    localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

// ==== verilog/game_pkg.sv ====
package game_pkg;

    // width of the shown pattern and of the player's guess
    localparam int PATTERN_BITS = 7;

    // internal register width of the pattern generator
    localparam int LFSR_BITS = 16;

    // compared bits for rounds 0, 1 and 2
    localparam int ROUND_WIDTH [3] = '{5, 6, 7};

    // controller states
    typedef enum logic [2:0]
    {
        IDLE,
        SHOW,
        PLAY,
        JUDGE,
        WIN
    } game_state_e;

endpackage
